/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [rv_pkg::xlen-1:0] a,
    input  logic [rv_pkg::xlen-1:0] b,
    input  rv_pkg::alu_op_t         alu_op,
    input  logic                    branch_ne,
    output logic [rv_pkg::xlen-1:0] result,
    output logic                    branch_cond
);

    always_comb begin
        case (alu_op)
            rv_pkg::alu_sub:    result = a - b;
            rv_pkg::alu_and:    result = a & b;
            rv_pkg::alu_or:     result = a | b;
            rv_pkg::alu_xor:    result = a ^ b;
            rv_pkg::alu_slt:    result = {{(rv_pkg::xlen-1){1'b0}}, $signed(a) < $signed(b)};
            rv_pkg::alu_pass_b: result = b;
            default:            result = a + b;
        endcase
    end

    // beq and bne share one comparator
    assign branch_cond = (a == b) ^ branch_ne;

endmodule

`default_nettype wire

/* build.f */
rv_pkg.sv
reg_file.sv
instr_decoder.sv
alu.sv
hazard_unit.sv
data_mem.sv
pipe_datapath.sv
rv_core.sv
tb_rv_core.sv

/* core_stimulus.txt */
// word 0: program length in words, word 1: number of expected retire records
// then one instruction word per line, then retire records as: rd value
1c
12
00500093 // 00 addi x1, x0, 5
00308113 // 04 addi x2, x1, 3
002081b3 // 08 add  x3, x1, x2
40118233 // 0c sub  x4, x3, x1
0041f2b3 // 10 and  x5, x3, x4
0040e333 // 14 or   x6, x1, x4
003343b3 // 18 xor  x7, x6, x3
0030a433 // 1c slt  x8, x1, x3
123454b7 // 20 lui  x9, 0x12345
00001517 // 24 auipc x10, 1
00302423 // 28 sw   x3, 8(x0)
00802583 // 2c lw   x11, 8(x0)
00258633 // 30 add  x12, x11, x2
00700013 // 34 addi x0, x0, 7
001006b3 // 38 add  x13, x0, x1
00108663 // 3c beq  x1, x1, +12
00100713 // 40 addi x14, x0, 1 (skipped)
00200713 // 44 addi x14, x0, 2 (skipped)
00109463 // 48 bne  x1, x1, +8
00900793 // 4c addi x15, x0, 9
00c0086f // 50 jal  x16, +12
00100893 // 54 addi x17, x0, 1 (skipped)
00200893 // 58 addi x17, x0, 2 (skipped)
00480913 // 5c addi x18, x16, 4
014909e7 // 60 jalr x19, 0x14(x18)
00100a13 // 64 addi x20, x0, 1 (skipped)
00200a13 // 68 addi x20, x0, 2 (skipped)
00198a93 // 6c addi x21, x19, 1
01 00000005
02 00000008
03 0000000d
04 00000008
05 00000008
06 0000000d
07 00000000
08 00000001
09 12345000
0a 00001024
0b 0000000d
0c 00000015
0d 00000005
0f 00000009
10 00000054
12 00000058
13 00000064
15 00000065

/* data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int dmem_words = 64
) (
    input  logic                    clk,
    input  logic [rv_pkg::xlen-1:0] addr,
    input  logic [rv_pkg::xlen-1:0] wdata,
    input  logic                    we,
    output logic [rv_pkg::xlen-1:0] rdata
);

    localparam int aw = $clog2(dmem_words);

    logic [rv_pkg::xlen-1:0] mem [dmem_words] = '{default: '0};
    logic [aw-1:0]           index;

    // byte address, low two bits select nothing
    assign index = addr[aw+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[index] <= wdata;
        end
    end

    assign rdata = mem[index];

    store_aligned: assert property (@(posedge clk) we |-> addr[1:0] == 2'b00)
        else $error("store to unaligned address %h", addr);

endmodule

`default_nettype wire

/* hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::reg_addr_w-1:0] d_rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] d_rs2,
    input  logic [6:0]                    d_opcode,
    input  logic [rv_pkg::reg_addr_w-1:0] e_rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] e_rs2,
    input  logic [rv_pkg::reg_addr_w-1:0] e_rd,
    input  logic [6:0]                    e_opcode,
    input  logic [rv_pkg::reg_addr_w-1:0] m_rd,
    input  logic                          m_we,
    input  logic [6:0]                    m_opcode,
    input  logic [rv_pkg::reg_addr_w-1:0] w_rd,
    input  logic                          w_we,
    input  logic [6:0]                    w_opcode,
    input  logic                          run,
    input  logic                          branch,
    input  logic                          branch_cond,
    input  logic                          jump,
    output rv_pkg::forward_type           fwd_a,
    output rv_pkg::forward_type           fwd_b,
    output logic                          pc_en,
    output logic                          fd_en,
    output logic                          de_en,
    output logic                          bubble,
    output logic                          redirect,
    output logic                          flush
);

    logic m_fwd_ok;
    logic w_fwd_ok;
    logic load_use;
    logic take;

    function automatic logic reads_rs1(input logic [6:0] op);
        return op == rv_pkg::op_jalr || op == rv_pkg::op_branch || op == rv_pkg::op_load
            || op == rv_pkg::op_store || op == rv_pkg::op_imm || op == rv_pkg::op_reg;
    endfunction

    function automatic logic reads_rs2(input logic [6:0] op);
        return op == rv_pkg::op_branch || op == rv_pkg::op_store || op == rv_pkg::op_reg;
    endfunction

    function automatic logic writes_rd(input logic [6:0] op, input logic we,
                                       input logic [rv_pkg::reg_addr_w-1:0] rd);
        return we && rd != '0 && op != rv_pkg::op_nop && op != rv_pkg::op_store
            && op != rv_pkg::op_branch;
    endfunction

    // load data is not ready in memory, the stall covers that case
    assign m_fwd_ok = writes_rd(m_opcode, m_we, m_rd) && m_opcode != rv_pkg::op_load;
    assign w_fwd_ok = writes_rd(w_opcode, w_we, w_rd);

    always_comb begin
        fwd_a = rv_pkg::fwd_none;
        fwd_b = rv_pkg::fwd_none;
        // the younger producer wins
        if (reads_rs1(e_opcode) && m_fwd_ok && e_rs1 == m_rd) begin
            fwd_a = rv_pkg::fwd_mem;
        end else if (reads_rs1(e_opcode) && w_fwd_ok && e_rs1 == w_rd) begin
            fwd_a = rv_pkg::fwd_writeback;
        end
        if (reads_rs2(e_opcode) && m_fwd_ok && e_rs2 == m_rd) begin
            fwd_b = rv_pkg::fwd_mem;
        end else if (reads_rs2(e_opcode) && w_fwd_ok && e_rs2 == w_rd) begin
            fwd_b = rv_pkg::fwd_writeback;
        end
    end

    assign load_use = e_opcode == rv_pkg::op_load && e_rd != '0
        && ((reads_rs1(d_opcode) && d_rs1 == e_rd) || (reads_rs2(d_opcode) && d_rs2 == e_rd));

    assign take = branch ? branch_cond : jump;
    // a branch held in execute by a freeze resolves once run returns
    assign redirect = run && take;
    assign flush    = redirect;

    always_comb begin
        pc_en  = 1'b1;
        fd_en  = 1'b1;
        de_en  = 1'b1;
        bubble = 1'b0;
        if (!run) begin
            pc_en  = 1'b0;
            fd_en  = 1'b0;
            de_en  = 1'b0;
            bubble = 1'b1;
        end else if (load_use && !take) begin
            pc_en  = 1'b0;
            fd_en  = 1'b0;
            bubble = 1'b1;
        end
    end

    no_flush_with_stall: assert property (@(posedge clk) disable iff (reset)
        !(flush && load_use))
        else $error("flush and load-use stall in the same cycle");

    // the inserted bubble clears the hazard on the next edge
    stall_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (load_use && run) |=> !load_use)
        else $error("load-use stall lasted more than one cycle");

endmodule

`default_nettype wire

/* instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  logic [rv_pkg::xlen-1:0]       dec_instr,
    output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [rv_pkg::reg_addr_w-1:0] rd_addr,
    output logic [rv_pkg::xlen-1:0]       imm,
    output logic [6:0]                    opcode,
    output rv_pkg::alu_op_t               alu_op,
    output logic                          use_imm,
    output logic                          reg_write,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic                          branch,
    output logic                          branch_ne,
    output logic                          jump
);

    logic [2:0]               funct3;
    logic [rv_pkg::xlen-1:0]  imm_i;
    logic [rv_pkg::xlen-1:0]  imm_s;
    logic [rv_pkg::xlen-1:0]  imm_b;
    logic [rv_pkg::xlen-1:0]  imm_u;
    logic [rv_pkg::xlen-1:0]  imm_j;

    assign rd_addr  = dec_instr[11:7];
    assign funct3   = dec_instr[14:12];
    assign rs1_addr = dec_instr[19:15];
    assign rs2_addr = dec_instr[24:20];

    assign imm_i = {{20{dec_instr[31]}}, dec_instr[31:20]};
    assign imm_s = {{20{dec_instr[31]}}, dec_instr[31:25], dec_instr[11:7]};
    assign imm_b = {{19{dec_instr[31]}}, dec_instr[31], dec_instr[7], dec_instr[30:25],
                    dec_instr[11:8], 1'b0};
    assign imm_u = {dec_instr[31:12], 12'b0};
    assign imm_j = {{11{dec_instr[31]}}, dec_instr[31], dec_instr[19:12], dec_instr[20],
                    dec_instr[30:21], 1'b0};

    always_comb begin
        opcode    = dec_instr[6:0];
        imm       = imm_i;
        alu_op    = rv_pkg::alu_add;
        use_imm   = 1'b0;
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        branch_ne = 1'b0;
        jump      = 1'b0;
        case (dec_instr[6:0])
            rv_pkg::op_lui: begin
                imm       = imm_u;
                use_imm   = 1'b1;
                alu_op    = rv_pkg::alu_pass_b;
                reg_write = 1'b1;
            end
            rv_pkg::op_auipc: begin
                imm       = imm_u;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            rv_pkg::op_jal: begin
                imm       = imm_j;
                reg_write = 1'b1;
                jump      = 1'b1;
            end
            rv_pkg::op_jalr: begin
                reg_write = 1'b1;
                jump      = 1'b1;
            end
            rv_pkg::op_branch: begin
                imm = imm_b;
                // only beq and bne are kept
                if (funct3[2:1] == 2'b00) begin
                    branch    = 1'b1;
                    branch_ne = funct3[0];
                end else begin
                    opcode = rv_pkg::op_nop;
                end
            end
            rv_pkg::op_load: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                mem_read  = 1'b1;
            end
            rv_pkg::op_store: begin
                imm       = imm_s;
                use_imm   = 1'b1;
                mem_write = 1'b1;
            end
            rv_pkg::op_imm, rv_pkg::op_reg: begin
                use_imm   = dec_instr[6:0] == rv_pkg::op_imm;
                reg_write = 1'b1;
                case (funct3)
                    3'b000: begin
                        if (dec_instr[6:0] == rv_pkg::op_reg && dec_instr[30]) begin
                            alu_op = rv_pkg::alu_sub;
                        end
                    end
                    3'b010: alu_op = rv_pkg::alu_slt;
                    3'b100: alu_op = rv_pkg::alu_xor;
                    3'b110: alu_op = rv_pkg::alu_or;
                    3'b111: alu_op = rv_pkg::alu_and;
                    default: begin
                        opcode    = rv_pkg::op_nop;
                        reg_write = 1'b0;
                    end
                endcase
            end
            default: opcode = rv_pkg::op_nop;
        endcase
    end

endmodule

`default_nettype wire

/* pipe_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_datapath (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::xlen-1:0]       instr,
    input  logic [rv_pkg::reg_addr_w-1:0] dec_rs1,
    input  logic [rv_pkg::reg_addr_w-1:0] dec_rs2,
    input  logic [rv_pkg::reg_addr_w-1:0] dec_rd,
    input  logic [rv_pkg::xlen-1:0]       dec_imm,
    input  logic [6:0]                    dec_opcode,
    input  rv_pkg::alu_op_t               dec_alu_op,
    input  logic                          dec_use_imm,
    input  logic                          dec_reg_write,
    input  logic                          dec_mem_read,
    input  logic                          dec_mem_write,
    input  logic                          dec_branch,
    input  logic                          dec_branch_ne,
    input  logic                          dec_jump,
    input  logic [rv_pkg::xlen-1:0]       rs1_data,
    input  logic [rv_pkg::xlen-1:0]       rs2_data,
    input  logic [rv_pkg::xlen-1:0]       alu_result,
    input  logic [rv_pkg::xlen-1:0]       load_data,
    input  rv_pkg::forward_type           fwd_a,
    input  rv_pkg::forward_type           fwd_b,
    input  logic                          pc_en,
    input  logic                          fd_en,
    input  logic                          de_en,
    input  logic                          bubble,
    input  logic                          redirect,
    input  logic                          flush,
    output logic [rv_pkg::xlen-1:0]       pc,
    output logic [rv_pkg::xlen-1:0]       dec_instr,
    output logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [rv_pkg::xlen-1:0]       alu_a,
    output logic [rv_pkg::xlen-1:0]       alu_b,
    output rv_pkg::alu_op_t               alu_op,
    output logic                          alu_branch_ne,
    output logic [rv_pkg::xlen-1:0]       mem_addr,
    output logic [rv_pkg::xlen-1:0]       mem_wdata,
    output logic                          mem_we,
    output logic [rv_pkg::reg_addr_w-1:0] e_rs1,
    output logic [rv_pkg::reg_addr_w-1:0] e_rs2,
    output logic [rv_pkg::reg_addr_w-1:0] e_rd,
    output logic [6:0]                    e_opcode,
    output logic [rv_pkg::reg_addr_w-1:0] m_rd,
    output logic                          m_we,
    output logic [6:0]                    m_opcode,
    output logic [rv_pkg::reg_addr_w-1:0] w_rd,
    output logic                          w_we,
    output logic [6:0]                    w_opcode,
    output logic [rv_pkg::xlen-1:0]       w_data,
    output logic                          branch,
    output logic                          jump,
    output logic                          retire_valid
);

    logic [rv_pkg::xlen-1:0] d_pc;
    logic [rv_pkg::xlen-1:0] e_pc;
    logic [rv_pkg::xlen-1:0] e_imm;
    logic [rv_pkg::xlen-1:0] e_rs1_data;
    logic [rv_pkg::xlen-1:0] e_rs2_data;
    logic                    e_use_imm;
    logic                    e_we;
    logic                    e_mem_read;
    logic                    e_mem_write;
    logic [rv_pkg::xlen-1:0] fwd_a_val;
    logic [rv_pkg::xlen-1:0] fwd_b_val;
    logic [rv_pkg::xlen-1:0] jalr_sum;
    logic [rv_pkg::xlen-1:0] target;
    logic [rv_pkg::xlen-1:0] e_result;
    logic                    m_mem_read;
    logic                    mem_we_q;
    logic [rv_pkg::xlen-1:0] m_result;

    function automatic logic [rv_pkg::xlen-1:0] fwd_pick(
        input rv_pkg::forward_type sel, input logic [rv_pkg::xlen-1:0] reg_val,
        input logic [rv_pkg::xlen-1:0] m_val, input logic [rv_pkg::xlen-1:0] w_val);
        case (sel)
            rv_pkg::fwd_mem:       return m_val;
            rv_pkg::fwd_writeback: return w_val;
            default:               return reg_val;
        endcase
    endfunction

    assign rs1_addr = dec_rs1;
    assign rs2_addr = dec_rs2;

    // execute stage
    assign fwd_a_val = fwd_pick(fwd_a, e_rs1_data, m_result, w_data);
    assign fwd_b_val = fwd_pick(fwd_b, e_rs2_data, m_result, w_data);
    assign alu_a     = e_opcode == rv_pkg::op_auipc ? e_pc : fwd_a_val;
    assign alu_b     = e_use_imm ? e_imm : fwd_b_val;
    assign jalr_sum  = fwd_a_val + e_imm;
    assign target    = e_opcode == rv_pkg::op_jalr ? {jalr_sum[rv_pkg::xlen-1:1], 1'b0}
                                                   : e_pc + e_imm;
    // jumps write the link address
    assign e_result  = jump ? e_pc + 32'd4 : alu_result;

    assign mem_addr  = m_result;
    assign mem_we    = mem_we_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (pc_en) begin
            pc <= redirect ? target : pc + 32'd4;
        end
    end

    // fetch/decode, wrong-path fetch dropped on a redirect
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_instr <= '0;
        end else if (fd_en) begin
            dec_instr <= flush ? '0 : instr;
            d_pc      <= pc;
        end
    end

    // decode/execute control
    always_ff @(posedge clk) begin
        if (reset || (de_en && (bubble || flush))) begin
            e_opcode      <= rv_pkg::op_nop;
            e_we          <= 1'b0;
            e_mem_read    <= 1'b0;
            e_mem_write   <= 1'b0;
            branch        <= 1'b0;
            jump          <= 1'b0;
        end else if (de_en) begin
            e_opcode      <= dec_opcode;
            e_we          <= dec_reg_write;
            e_mem_read    <= dec_mem_read;
            e_mem_write   <= dec_mem_write;
            branch        <= dec_branch;
            jump          <= dec_jump;
        end
    end

    always_ff @(posedge clk) begin
        if (de_en) begin
            e_pc          <= d_pc;
            e_rs1         <= dec_rs1;
            e_rs2         <= dec_rs2;
            e_rd          <= dec_rd;
            e_imm         <= dec_imm;
            alu_op        <= dec_alu_op;
            e_use_imm     <= dec_use_imm;
            alu_branch_ne <= dec_branch_ne;
            e_rs1_data    <= rs1_data;
            e_rs2_data    <= rs2_data;
        end else begin
            // frozen in execute, operands follow producers as they drain
            e_rs1_data    <= fwd_a_val;
            e_rs2_data    <= fwd_b_val;
        end
    end

    // execute/memory, a frozen execute sends a bubble on
    always_ff @(posedge clk) begin
        if (reset || !de_en) begin
            m_opcode   <= rv_pkg::op_nop;
            m_we       <= 1'b0;
            m_mem_read <= 1'b0;
            mem_we_q   <= 1'b0;
        end else begin
            m_opcode   <= e_opcode;
            m_we       <= e_we;
            m_mem_read <= e_mem_read;
            mem_we_q   <= e_mem_write;
        end
        m_rd      <= e_rd;
        m_result  <= e_result;
        mem_wdata <= fwd_b_val;
    end

    // memory/writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            w_opcode <= rv_pkg::op_nop;
            w_we     <= 1'b0;
        end else begin
            w_opcode <= m_opcode;
            w_we     <= m_we;
        end
        w_rd   <= m_rd;
        w_data <= m_mem_read ? load_data : m_result;
    end

    assign retire_valid = w_we && w_rd != '0;

    // the two flushed slots reach writeback as bubbles
    flush_kills_young: assert property (@(posedge clk) disable iff (reset)
        flush |=> ##2 !w_we ##1 !w_we)
        else $error("flushed instruction still writes a register");

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic                          we,
    input  logic [rv_pkg::reg_addr_w-1:0] rd_addr,
    input  logic [rv_pkg::xlen-1:0]       rd_data,
    output logic [rv_pkg::xlen-1:0]       rs1_data,
    output logic [rv_pkg::xlen-1:0]       rs2_data
);

    // x0 has no storage
    logic [rv_pkg::xlen-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // writeback result bypasses the array so decode sees it this cycle
    always_comb begin
        if (rs1_addr == '0) begin
            rs1_data = '0;
        end else if (we && rs1_addr == rd_addr) begin
            rs1_data = rd_data;
        end else begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr == '0) begin
            rs2_data = '0;
        end else if (we && rs2_addr == rd_addr) begin
            rs2_data = rd_data;
        end else begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_rv_core -f build.f --Mdir obj_dir

# the simulation status is not trusted on its own, the log decides
./obj_dir/Vtb_rv_core > sim.log 2>&1 || true
cat sim.log

grep -qx "TEST OK" sim.log

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
    parameter int dmem_words = 64
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    input  logic [rv_pkg::xlen-1:0]       instr,
    output logic [rv_pkg::xlen-1:0]       pc,
    output logic                          retire_valid,
    output logic [rv_pkg::reg_addr_w-1:0] retire_rd,
    output logic [rv_pkg::xlen-1:0]       retire_data
);

    logic [rv_pkg::xlen-1:0]       dec_instr;
    logic [rv_pkg::reg_addr_w-1:0] dec_rs1;
    logic [rv_pkg::reg_addr_w-1:0] dec_rs2;
    logic [rv_pkg::reg_addr_w-1:0] dec_rd;
    logic [rv_pkg::xlen-1:0]       dec_imm;
    logic [6:0]                    dec_opcode;
    rv_pkg::alu_op_t               dec_alu_op;
    logic                          dec_use_imm;
    logic                          dec_reg_write;
    logic                          dec_mem_read;
    logic                          dec_mem_write;
    logic                          dec_branch;
    logic                          dec_branch_ne;
    logic                          dec_jump;
    logic [rv_pkg::reg_addr_w-1:0] rs1_addr;
    logic [rv_pkg::reg_addr_w-1:0] rs2_addr;
    logic [rv_pkg::xlen-1:0]       rs1_data;
    logic [rv_pkg::xlen-1:0]       rs2_data;
    logic [rv_pkg::xlen-1:0]       alu_a;
    logic [rv_pkg::xlen-1:0]       alu_b;
    rv_pkg::alu_op_t               alu_op;
    logic                          alu_branch_ne;
    logic [rv_pkg::xlen-1:0]       alu_result;
    logic                          branch_cond;
    logic [rv_pkg::xlen-1:0]       mem_addr;
    logic [rv_pkg::xlen-1:0]       mem_wdata;
    logic                          mem_we;
    logic [rv_pkg::xlen-1:0]       load_data;
    logic [rv_pkg::reg_addr_w-1:0] e_rs1;
    logic [rv_pkg::reg_addr_w-1:0] e_rs2;
    logic [rv_pkg::reg_addr_w-1:0] e_rd;
    logic [6:0]                    e_opcode;
    logic [rv_pkg::reg_addr_w-1:0] m_rd;
    logic                          m_we;
    logic [6:0]                    m_opcode;
    logic                          w_we;
    logic [6:0]                    w_opcode;
    logic                          branch;
    logic                          jump;
    rv_pkg::forward_type           fwd_a;
    rv_pkg::forward_type           fwd_b;
    logic                          pc_en;
    logic                          fd_en;
    logic                          de_en;
    logic                          bubble;
    logic                          redirect;
    logic                          flush;

    pipe_datapath u_datapath (
        .clk(clk), .reset(reset), .instr(instr),
        .dec_rs1(dec_rs1), .dec_rs2(dec_rs2), .dec_rd(dec_rd), .dec_imm(dec_imm),
        .dec_opcode(dec_opcode), .dec_alu_op(dec_alu_op), .dec_use_imm(dec_use_imm),
        .dec_reg_write(dec_reg_write), .dec_mem_read(dec_mem_read),
        .dec_mem_write(dec_mem_write), .dec_branch(dec_branch),
        .dec_branch_ne(dec_branch_ne), .dec_jump(dec_jump),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .alu_result(alu_result),
        .load_data(load_data), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .pc_en(pc_en), .fd_en(fd_en), .de_en(de_en), .bubble(bubble),
        .redirect(redirect), .flush(flush),
        .pc(pc), .dec_instr(dec_instr), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .alu_branch_ne(alu_branch_ne),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we),
        .e_rs1(e_rs1), .e_rs2(e_rs2), .e_rd(e_rd), .e_opcode(e_opcode),
        .m_rd(m_rd), .m_we(m_we), .m_opcode(m_opcode),
        .w_rd(retire_rd), .w_we(w_we), .w_opcode(w_opcode), .w_data(retire_data),
        .branch(branch), .jump(jump), .retire_valid(retire_valid)
    );

    instr_decoder u_decoder (
        .dec_instr(dec_instr), .rs1_addr(dec_rs1), .rs2_addr(dec_rs2), .rd_addr(dec_rd),
        .imm(dec_imm), .opcode(dec_opcode), .alu_op(dec_alu_op), .use_imm(dec_use_imm),
        .reg_write(dec_reg_write), .mem_read(dec_mem_read), .mem_write(dec_mem_write),
        .branch(dec_branch), .branch_ne(dec_branch_ne), .jump(dec_jump)
    );

    reg_file u_reg_file (
        .clk(clk), .reset(reset), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .we(w_we), .rd_addr(retire_rd), .rd_data(retire_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    alu u_alu (
        .a(alu_a), .b(alu_b), .alu_op(alu_op), .branch_ne(alu_branch_ne),
        .result(alu_result), .branch_cond(branch_cond)
    );

    data_mem #(.dmem_words(dmem_words)) u_data_mem (
        .clk(clk), .addr(mem_addr), .wdata(mem_wdata), .we(mem_we), .rdata(load_data)
    );

    hazard_unit u_hazard (
        .clk(clk), .reset(reset),
        .d_rs1(rs1_addr), .d_rs2(rs2_addr), .d_opcode(dec_opcode),
        .e_rs1(e_rs1), .e_rs2(e_rs2), .e_rd(e_rd), .e_opcode(e_opcode),
        .m_rd(m_rd), .m_we(m_we), .m_opcode(m_opcode),
        .w_rd(retire_rd), .w_we(w_we), .w_opcode(w_opcode),
        .run(run), .branch(branch), .branch_cond(branch_cond), .jump(jump),
        .fwd_a(fwd_a), .fwd_b(fwd_b), .pc_en(pc_en), .fd_en(fd_en), .de_en(de_en),
        .bubble(bubble), .redirect(redirect), .flush(flush)
    );

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // base opcodes of the rv32i subset
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;

    // bubble marker, no real instruction uses it
    localparam logic [6:0] op_nop    = 7'b0000000;

    typedef enum logic [1:0] {
        fwd_none      = 2'b00,
        fwd_mem       = 2'b01,
        fwd_writeback = 2'b10
    } forward_type;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

endpackage

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int stim_words   = 128;
    localparam int prog_base    = 2;
    localparam int sched_len    = 1024;
    localparam int pipe_depth   = 4;
    localparam int drain_cycles = 12;

    logic        clk;
    logic        reset;
    logic        run;
    logic [31:0] instr;
    logic [31:0] pc;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    logic [31:0] stim [stim_words];
    logic        run_sched [sched_len];
    logic [31:0] word_idx;
    int          prog_len;
    int          rec_count;
    int          rec_base;
    int          rec_idx;
    int          cyc;
    int          first_cyc;
    int          limit;
    int          test_errors;
    int          errors;
    int          tests;
    logic        idle_check;
    logic        monitor_on;

    rv_core #(.dmem_words(64)) DUT (
        .clk(clk), .reset(reset), .run(run), .instr(instr), .pc(pc),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_data(retire_data)
    );

    always #50 clk = ~clk;

    // instruction ROM, past the end of the program it returns bubbles
    assign word_idx = {2'b00, pc[31:2]};
    always_comb begin
        if (int'(word_idx) < prog_len) begin
            instr = stim[prog_base + int'(word_idx)];
        end else begin
            instr = '0;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    // retire stream checked against the expected records in order
    always @(negedge clk) begin
        if (idle_check) begin
            // fetch starts from address zero
            compare_value("pc", pc, 32'h0);
            if (retire_valid) begin
                $display("retire_valid was high while reset was asserted");
                test_errors++;
            end
        end
        if (monitor_on && retire_valid) begin
            if (cyc < pipe_depth) begin
                $display("a retire came out before the first instruction reached writeback");
                test_errors++;
            end
            if (first_cyc < 0) begin
                first_cyc = cyc;
            end
            if (rec_idx >= rec_count) begin
                $display("extra retire of x%0d after the last expected record", retire_rd);
                test_errors++;
            end else begin
                compare_value("retire_rd", {27'b0, retire_rd}, stim[rec_base + 2 * rec_idx]);
                compare_value("retire_data", retire_data, stim[rec_base + 2 * rec_idx + 1]);
                rec_idx++;
            end
        end
    end

    task automatic run_program(input string label, input bit with_freeze);
        int freeze_cycles;
        freeze_cycles = 0;
        for (int i = 0; i < sched_len; i++) begin
            run_sched[i] = 1'b1;
            // freeze windows only where the program can still be running
            if (with_freeze && i < 10 * prog_len) begin
                run_sched[i] = ($urandom % 4) != 0;
            end
            if (!run_sched[i]) begin
                freeze_cycles++;
            end
        end
        limit       = 10 * prog_len + freeze_cycles + 50;
        rec_idx     = 0;
        first_cyc   = -1;
        test_errors = 0;
        cyc         = 0;
        run         = 1'b1;
        reset       = 1'b1;
        @(posedge clk);
        idle_check = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset      = 1'b0;
        idle_check = 1'b0;
        monitor_on = 1'b1;
        run        = run_sched[0];
        while (rec_idx < rec_count && cyc < limit) begin
            @(posedge clk);
            #1;
            cyc++;
            run = run_sched[cyc];
        end
        if (rec_idx < rec_count) begin
            $display("timeout in %s after %0d cycles, only %0d of %0d retires seen",
                     label, cyc, rec_idx, rec_count);
            $display("TEST FAILED");
            $finish;
        end
        // nothing more may retire once the program has run out
        run = 1'b1;
        repeat (drain_cycles) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        monitor_on = 1'b0;
        if (!with_freeze) begin
            compare_value("first_retire_cycle", first_cyc, pipe_depth);
        end
        $display("%s: %0d retires checked, %0d errors", label, rec_idx, test_errors);
        errors += test_errors;
        tests++;
    endtask

    initial begin
        void'($urandom(8938));
        clk        = 1'b0;
        reset      = 1'b1;
        run        = 1'b1;
        idle_check = 1'b0;
        monitor_on = 1'b0;
        errors     = 0;
        tests      = 0;
        prog_len   = 0;
        $readmemh("core_stimulus.txt", stim);
        prog_len  = int'(stim[0]);
        rec_count = int'(stim[1]);
        rec_base  = prog_base + prog_len;

        run_program("straight run", 1'b0);
        run_program("random freeze", 1'b1);

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
